// ==== branch_cluster.f ====
verilog/branch_pkg.sv
verilog/branch_issue.sv
verilog/branch_unit.sv
verilog/branch_resolve.sv
verilog/branch_cluster.sv
bench/branch_cluster_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the branch cluster testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f branch_cluster.f \
  --top-module branch_cluster_tb -o branch_cluster_sim &&
./obj_dir/branch_cluster_sim | tee /dev/stderr | grep -q "^sim passed$" &&
echo "PASS" || { echo "FAIL"; exit 1; }

// ==== bench/branch_cluster_tb.sv ====
`timescale 1ns/10ps

module branch_cluster_tb;
  import branch_pkg::*;

  localparam int RAND_CYCLES  = 300;
  // reset plus every test where each test ends with 3 idle cycles
  localparam int TOTAL_CYCLES = 2 + 5 + 21 + 7 + 7 + 5 + RAND_CYCLES + 3;

  // expected outputs of one request group
  typedef struct packed {
    wb_t [LANES-1:0]    wb;
    redirect_t          redirect;
    train_t [LANES-1:0] train;
  } expect_t;

  // starts low before any process runs so no edge is seen at time 0
  logic        cpu_clock = 1'b0;
  logic        rst;
  logic        flush;
  branch_req_t req [LANES];
  wb_t         wb [LANES];
  redirect_t   redirect;
  train_t      train [LANES];

  integer seed;
  int     errors;
  int     last_errors;
  int     tests_passed;
  int     tests_failed;

  // input groups and kill bits seen at the last two negedges
  branch_req_t [LANES-1:0] hist_grp [$];
  logic                    hist_kill [$];

  branch_cluster branch_cluster_i (
    .cpu_clock (cpu_clock),
    .rst       (rst),
    .flush     (flush),
    .req       (req),
    .wb        (wb),
    .redirect  (redirect),
    .train     (train)
  );

  always #20 cpu_clock = !cpu_clock;

  // one lane resolved from the request fields
  function automatic branch_res_t lane_model(input branch_req_t r);
    branch_res_t o;
    logic        mt;
    logic        lt;
    logic        eq;
    logic        outcome;
    word_t       pc_b;
    pc_b = {r.pc, 2'b00};
    eq   = r.rs1 == r.rs2;
    mt   = r.cond[1] ? (r.rs1 > r.rs2) : ($signed(r.rs1) > $signed(r.rs2));
    lt   = !mt && !eq;
    case (r.cond)
      3'b000:         outcome = eq;
      3'b001:         outcome = !eq;
      3'b100, 3'b110: outcome = lt;
      3'b101, 3'b111: outcome = mt || eq;
      default:        outcome = 1'b0;
    endcase
    o.taken = r.jal || r.jalr || (outcome && !r.auipc);
    if (r.call) o.btype = BT_CALL;
    else if (r.ret) o.btype = BT_RET;
    else if (r.jal || r.jalr) o.btype = BT_JUMP;
    else o.btype = BT_COND;
    o.target = (r.jalr ? r.rs1 : pc_b) + ((o.taken && !r.auipc) ? r.imm : 32'd4);
    o.result = r.auipc ? pc_b + r.imm : pc_b + 32'd4;
    return o;
  endfunction

  // whole group where the oldest mispredict wins and younger lanes drop out
  function automatic expect_t group_model(input branch_req_t [LANES-1:0] g, input logic kill);
    expect_t     e;
    branch_res_t rs;
    logic        bad;
    logic        found;
    e     = '0;
    found = 1'b0;
    for (int i = 0; i < LANES; i++) begin
      rs = lane_model(g[i]);
      e.wb[i].result = rs.result;
      if (g[i].valid && !found && !kill) begin
        if (!g[i].pred.btb_vld) begin
          bad = rs.taken || (rs.btype != BT_COND);
        end else begin
          bad = (rs.taken && ({g[i].pred.btb_target, 2'b00} != rs.target)) ||
                (g[i].pred.btype != rs.btype) ||
                ((rs.btype == BT_COND) && (rs.taken != g[i].pred.bm_pred[1]));
        end
        bad = bad && !g[i].auipc;
        e.wb[i].valid = 1'b1;
        if (bad) begin
          e.redirect.valid = 1'b1;
          e.redirect.addr  = rs.target;
          e.redirect.lane  = lane_t'(i);
          found            = 1'b1;
        end else if (g[i].pred.btb_vld && !g[i].auipc) begin
          if (g[i].call) e.train[i].call_affirm = 1'b1;
          else if (g[i].ret) e.train[i].ret_affirm = 1'b1;
          else begin
            e.train[i].bm_update = 1'b1;
            e.train[i].taken     = rs.taken;
          end
        end
      end
    end
    return e;
  endfunction

  // fills the prediction fields with what the lane will really do
  function automatic branch_req_t predict_right(input branch_req_t r);
    branch_res_t rs;
    rs = lane_model(r);
    r.pred.btb_vld    = 1'b1;
    r.pred.btb_target = rs.target[31:2];
    r.pred.btype      = rs.btype;
    r.pred.bm_pred    = {rs.taken, 1'b0};
    return r;
  endfunction

  function automatic cond_t cond_code(input int k);
    case (k)
      0: return 3'b000;
      1: return 3'b001;
      2: return 3'b100;
      3: return 3'b101;
      4: return 3'b110;
      default: return 3'b111;
    endcase
  endfunction

  task automatic mismatch(input string name, input word_t exp, input word_t act);
    errors++;
    $display("Error at %0t ns: %s expected %h actual %h", $time, name, exp, act);
  endtask

  task automatic check_outputs(input expect_t e);
    for (int i = 0; i < LANES; i++) begin
      if (wb[i].valid !== e.wb[i].valid)
        mismatch($sformatf("wb[%0d].valid", i), word_t'(e.wb[i].valid), word_t'(wb[i].valid));
      else if (e.wb[i].valid && wb[i].result !== e.wb[i].result)
        mismatch($sformatf("wb[%0d].result", i), e.wb[i].result, wb[i].result);
      if (train[i] !== e.train[i])
        mismatch($sformatf("train[%0d]", i), word_t'(e.train[i]), word_t'(train[i]));
    end
    if (redirect.valid !== e.redirect.valid)
      mismatch("redirect.valid", word_t'(e.redirect.valid), word_t'(redirect.valid));
    else if (e.redirect.valid && redirect.addr !== e.redirect.addr)
      mismatch("redirect.addr", e.redirect.addr, redirect.addr);
    else if (e.redirect.valid && redirect.lane !== e.redirect.lane)
      mismatch("redirect.lane", word_t'(e.redirect.lane), word_t'(redirect.lane));
  endtask

  // inputs are stable at the negedge and outputs show the group from two negedges back
  always @(negedge cpu_clock) begin : compare_proc
    branch_req_t [LANES-1:0] cur;
    for (int i = 0; i < LANES; i++) cur[i] = req[i];
    if (hist_grp.size() == 2) begin
      check_outputs(group_model(hist_grp[0], hist_kill[0] || hist_kill[1]));
      void'(hist_grp.pop_front());
      void'(hist_kill.pop_front());
    end
    hist_grp.push_back(cur);
    hist_kill.push_back(flush || rst);
  end

  task automatic drive_group(input branch_req_t [LANES-1:0] g, input logic f);
    @(posedge cpu_clock);
    for (int i = 0; i < LANES; i++) req[i] <= g[i];
    flush <= f;
  endtask

  // drains the pipeline and prints one line per test
  task automatic finish_test(input string name);
    repeat (3) drive_group('0, 1'b0);
    if (errors == last_errors) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d mismatches", name, errors - last_errors);
    end
    last_errors = errors;
  endtask

  task automatic rand_req(output branch_req_t r);
    word_t a;
    word_t b;
    word_t c;
    word_t d;
    a = $random(seed);
    b = $random(seed);
    c = $random(seed);
    d = $random(seed);
    r       = '0;
    r.valid = c[3:0] != 4'h0;
    r.rs1   = a;
    // equal operands come up often enough to matter
    r.rs2   = c[4] ? a : b;
    r.imm   = {{20{d[11]}}, d[11:2], 2'b00};
    r.pc    = {a[9:0], d[31:12]};
    r.cond  = cond_code(int'(c[10:8]) % 6);
    case (c[7:5])
      3'd1: r.jal = 1'b1;
      3'd2: r.jalr = 1'b1;
      3'd3: {r.jal, r.call} = 2'b11;
      3'd4: {r.jalr, r.ret} = 2'b11;
      3'd5: r.auipc = 1'b1;
      default: r.auipc = 1'b0;
    endcase
    if (c[11]) begin
      r = predict_right(r);
      if (c[12]) r.pred.bm_pred = r.pred.bm_pred ^ 2'b10;
    end else begin
      r.pred = {c[13], b[29:0], c[15:14], c[17:16]};
    end
  endtask

  task automatic flush_kills_groups();
    branch_req_t [LANES-1:0] g;
    g = '0;
    g[0].valid = 1'b1;
    g[1].valid = 1'b1;
    g[0].jal   = 1'b1;
    drive_group(g, 1'b0);
    // this flush catches both groups in flight
    drive_group(g, 1'b1);
    finish_test("reset_flush");
  endtask

  task automatic cond_branches();
    branch_req_t [LANES-1:0] g;
    word_t                   w;
    word_t                   a [3];
    word_t                   b [3];
    a = '{32'd5, 32'd7, 32'hffff_fff0};
    b = '{32'd5, 32'hffff_fffd, 32'h0000_0010};
    for (int c = 0; c < 6; c++) begin
      for (int p = 0; p < 3; p++) begin
        w = $random(seed);
        g = '0;
        g[0].valid = 1'b1;
        g[0].rs1   = a[p];
        g[0].rs2   = b[p];
        g[0].cond  = cond_code(c);
        g[0].pc    = 30'h400 + 30'(c * 3 + p);
        g[0].imm   = 32'h80;
        g[0].pred  = {w[0], w[30:1], w[31], w[0], w[2:1]};
        if (w[3]) g[0] = predict_right(g[0]);
        drive_group(g, 1'b0);
      end
    end
    finish_test("cond");
  endtask

  task automatic jumps_and_links();
    branch_req_t [LANES-1:0] g;
    for (int k = 0; k < 4; k++) begin
      g = '0;
      g[0].valid = 1'b1;
      g[0].pc    = 30'h800 + 30'(k);
      g[0].rs1   = 32'h2000_0010;
      g[0].imm   = 32'h100;
      g[0].jal   = (k == 0) || (k == 2);
      g[0].jalr  = (k == 1) || (k == 3);
      g[0].call  = k == 2;
      g[0].ret   = k == 3;
      g[0] = predict_right(g[0]);
      drive_group(g, 1'b0);
    end
    finish_test("jumps");
  endtask

  task automatic auipc_results();
    branch_req_t [LANES-1:0] g;
    for (int k = 0; k < 4; k++) begin
      rand_req(g[0]);
      rand_req(g[1]);
      for (int i = 0; i < LANES; i++) begin
        g[i].valid = 1'b1;
        g[i].auipc = 1'b1;
        {g[i].jal, g[i].jalr, g[i].call, g[i].ret} = 4'b0000;
      end
      drive_group(g, 1'b0);
    end
    finish_test("auipc");
  endtask

  task automatic oldest_mispredict();
    branch_req_t [LANES-1:0] g;
    g = '0;
    for (int i = 0; i < LANES; i++) begin
      g[i].valid = 1'b1;
      g[i].pc    = 30'h1000 + 30'(i);
      g[i].imm   = 32'h40;
    end
    // equal operands make beq taken with no target buffer hit in both lanes
    drive_group(g, 1'b0);
    // lane 0 a correctly predicted not taken bne
    g[0].cond = 3'b001;
    g[0] = predict_right(g[0]);
    drive_group(g, 1'b0);
    finish_test("oldest");
  endtask

  task automatic random_mix();
    branch_req_t [LANES-1:0] g;
    word_t                   f;
    for (int k = 0; k < RAND_CYCLES; k++) begin
      rand_req(g[0]);
      rand_req(g[1]);
      f = $random(seed);
      drive_group(g, f[4:0] == 5'd0);
    end
    finish_test("random");
  endtask

  initial begin
    rst          = 1'b1;
    flush        = 1'b0;
    seed         = 32'h445e_4064;
    errors       = 0;
    last_errors  = 0;
    tests_passed = 0;
    tests_failed = 0;
    for (int i = 0; i < LANES; i++) req[i] = '0;
    repeat (2) @(posedge cpu_clock);
    rst <= 1'b0;
    flush_kills_groups();
    cond_branches();
    jumps_and_links();
    auipc_results();
    oldest_mispredict();
    random_mix();
    $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #((TOTAL_CYCLES + 20) * 40);
    $display("the run timed out before all tests finished");
    $display("sim failed");
    $finish;
  end

endmodule

// ==== verilog/branch_cluster.sv ====
`timescale 1ns/10ps

module branch_cluster (
  input  logic                    cpu_clock,
  input  logic                    rst,
  input  logic                    flush,
  input  branch_pkg::branch_req_t req [branch_pkg::LANES],
  output branch_pkg::wb_t         wb  [branch_pkg::LANES],
  output branch_pkg::redirect_t   redirect,
  output branch_pkg::train_t      train [branch_pkg::LANES]
);
  import branch_pkg::*;

  // issued ops feed both the units and resolve
  branch_op_t  op  [LANES];
  branch_res_t res [LANES];

  branch_issue issue_i (
    .cpu_clock (cpu_clock),
    .rst       (rst),
    .flush     (flush),
    .req       (req),
    .op        (op)
  );

  // one combinational unit per lane
  for (genvar g = 0; g < LANES; g++) begin : g_lane
    branch_unit unit_i (
      .op  (op[g]),
      .res (res[g])
    );
  end

  branch_resolve resolve_i (
    .cpu_clock (cpu_clock),
    .rst       (rst),
    .flush     (flush),
    .op        (op),
    .res       (res),
    .wb        (wb),
    .redirect  (redirect),
    .train     (train)
  );

endmodule

// ==== verilog/branch_resolve.sv ====
`timescale 1ns/10ps

module branch_resolve (
  input  logic                    cpu_clock,
  input  logic                    rst,
  input  logic                    flush,
  input  branch_pkg::branch_op_t  op  [branch_pkg::LANES],
  input  branch_pkg::branch_res_t res [branch_pkg::LANES],
  output branch_pkg::wb_t         wb  [branch_pkg::LANES],
  output branch_pkg::redirect_t   redirect,
  output branch_pkg::train_t      train [branch_pkg::LANES]
);
  import branch_pkg::*;

  // per lane verdict, valid and auipc not yet applied
  logic [LANES-1:0] wrong;
  logic [LANES-1:0] mispredict;
  // correct prediction with a target buffer hit
  logic [LANES-1:0] confirm;
  // younger than the oldest mispredict
  logic [LANES-1:0] squash;
  logic             any_mispredict;
  lane_t            oldest;
  train_t           train_d [LANES];

  // mispredict rule per lane
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      if (!op[i].pred.btb_vld) begin
        // no hit means fetch fell through, so any taken or jump is wrong
        wrong[i] = res[i].taken || (res[i].btype != BT_COND);
      end else begin
        wrong[i] = (res[i].taken && ({op[i].pred.btb_target, 2'b00} != res[i].target)) ||
                   (op[i].pred.btype != res[i].btype) ||
                   ((res[i].btype == BT_COND) && (res[i].taken != op[i].pred.bm_pred[1]));
      end
      // auipc never mispredicts
      mispredict[i] = op[i].valid && !op[i].auipc && wrong[i];
      confirm[i]    = op[i].valid && !op[i].auipc && op[i].pred.btb_vld && !wrong[i];
    end
  end

  // priority scan, lane 0 is the oldest
  always_comb begin
    any_mispredict = 1'b0;
    oldest         = '0;
    for (int i = 0; i < LANES; i++) begin
      squash[i] = any_mispredict;
      if (mispredict[i] && !any_mispredict) begin
        any_mispredict = 1'b1;
        oldest         = lane_t'(i);
      end
    end
  end

  // training only for surviving correct hits
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      train_d[i].bm_update   = confirm[i] && !squash[i] && !(op[i].call || op[i].ret);
      // direction goes out with the bimodal update only
      train_d[i].taken       = train_d[i].bm_update && res[i].taken;
      train_d[i].call_affirm = confirm[i] && !squash[i] && op[i].call;
      train_d[i].ret_affirm  = confirm[i] && !squash[i] && op[i].ret;
    end
  end

  always_ff @(posedge cpu_clock) begin
    for (int i = 0; i < LANES; i++) begin
      wb[i].result <= res[i].result;
      if (rst || flush) begin
        wb[i].valid <= 1'b0;
        train[i]    <= '0;
      end else begin
        // the mispredicting lane itself still writes back
        wb[i].valid <= op[i].valid && !squash[i];
        train[i]    <= train_d[i];
      end
    end
    // fetch restarts at the oldest bad lane's resolved address
    redirect.addr <= res[oldest].target;
    redirect.lane <= oldest;
    if (rst || flush) begin
      redirect.valid <= 1'b0;
    end else begin
      redirect.valid <= any_mispredict;
    end
  end

  // a redirect always comes with its own lane's writeback
  assert property (@(posedge cpu_clock) disable iff (rst)
    redirect.valid |-> wb[redirect.lane].valid);

  for (genvar g = 0; g < LANES; g++) begin : g_chk
    // squashed or empty lanes never train the predictor
    assert property (@(posedge cpu_clock) disable iff (rst)
      (|train[g]) |-> wb[g].valid);
  end

endmodule

// ==== verilog/branch_unit.sv ====
`timescale 1ns/10ps

module branch_unit (
  input  branch_pkg::branch_op_t  op,
  output branch_pkg::branch_res_t res
);
  import branch_pkg::*;

  logic   mt;
  logic   lt;
  logic   outcome;
  logic   taken;
  word_t  pc_byte;
  word_t  first_operand;
  word_t  second_operand;
  btype_t btype;

  assign pc_byte = {op.pc, 2'b00};

  // cond[1] marks the unsigned compares
  assign mt = op.cond[1] ? op.mtu : op.mts;
  // neither greater nor equal means less
  assign lt = !(mt || op.eq);

  // cond[2] picks magnitude over equality, cond[0] inverts
  always_comb begin
    case ({op.cond[2], op.cond[0]})
      2'b00:   outcome = op.eq;
      2'b01:   outcome = !op.eq;
      2'b10:   outcome = lt;
      default: outcome = mt || op.eq;
    endcase
  end

  // jumps are always taken, auipc never is
  assign taken = op.jal || op.jalr || (outcome && !op.auipc);

  // target or fall through
  assign first_operand  = op.jalr ? op.operand_1 : pc_byte;
  assign second_operand = (taken && !op.auipc) ? op.offset : 32'd4;

  assign btype = op.call ? BT_CALL :
                 op.ret ? BT_RET :
                 (op.jal || op.jalr) ? BT_JUMP : BT_COND;

  assign res.taken  = taken;
  assign res.btype  = btype;
  assign res.target = first_operand + second_operand;
  // auipc result, or the link address
  assign res.result = op.auipc ? pc_byte + op.offset : pc_byte + 32'd4;

endmodule

// ==== verilog/branch_issue.sv ====
`timescale 1ns/10ps

module branch_issue (
  input  logic                    cpu_clock,
  input  logic                    rst,
  input  logic                    flush,
  input  branch_pkg::branch_req_t req [branch_pkg::LANES],
  output branch_pkg::branch_op_t  op  [branch_pkg::LANES]
);
  import branch_pkg::*;

  // next op per lane, before the register
  branch_op_t op_d [LANES];

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      op_d[i].valid     = req[i].valid;
      // rs1 doubles as the jalr base
      op_d[i].operand_1 = req[i].rs1;
      op_d[i].offset    = req[i].imm;
      op_d[i].pc        = req[i].pc;
      op_d[i].auipc     = req[i].auipc;
      op_d[i].call      = req[i].call;
      op_d[i].ret       = req[i].ret;
      op_d[i].jal       = req[i].jal;
      op_d[i].jalr      = req[i].jalr;
      op_d[i].cond      = req[i].cond;
      // signed and unsigned greater than, rs1 against rs2
      op_d[i].mts       = $signed(req[i].rs1) > $signed(req[i].rs2);
      op_d[i].mtu       = req[i].rs1 > req[i].rs2;
      op_d[i].eq        = req[i].rs1 == req[i].rs2;
      op_d[i].pred      = req[i].pred;
    end
  end

  // one cycle issue register
  always_ff @(posedge cpu_clock) begin
    for (int i = 0; i < LANES; i++) begin
      op[i] <= op_d[i];
      // flush kills the group being captured
      if (rst || flush) begin
        op[i].valid <= 1'b0;
      end
    end
  end

  for (genvar g = 0; g < LANES; g++) begin : g_chk
    // a lane is a jal, a jalr, an auipc or a plain branch, never two of them
    assert property (@(posedge cpu_clock) disable iff (rst)
      op[g].valid |-> $onehot0({op[g].auipc, op[g].jal, op[g].jalr}));
    // call and ret hints only ride on a jump
    assert property (@(posedge cpu_clock) disable iff (rst)
      op[g].valid && (op[g].call || op[g].ret) |-> op[g].jal || op[g].jalr);
  end

endmodule

// ==== verilog/branch_pkg.sv ====
package branch_pkg;

  // lane count and lane index width
  localparam int LANES  = 2;
  localparam int LANE_W = 1;

  // branch type codes, shared with the predictor
  // conditional branches and auipc both report as cond
  localparam logic [1:0] BT_COND = 2'b00;
  localparam logic [1:0] BT_CALL = 2'b01;
  localparam logic [1:0] BT_JUMP = 2'b10;
  localparam logic [1:0] BT_RET  = 2'b11;

  // data word or byte address
  typedef logic [31:0] word_t;
  // word aligned pc, byte address is {pc, 2'b00}
  typedef logic [29:0] wpc_t;
  // branch funct3
  // 000 eq, 001 ne, 100 lt, 101 ge, 110 ltu, 111 geu
  typedef logic [2:0] cond_t;
  typedef logic [1:0] btype_t;
  typedef logic [LANE_W-1:0] lane_t;

  // front end prediction carried with the instruction
  typedef struct packed {
    logic       btb_vld;
    wpc_t       btb_target;
    btype_t     btype;
    // msb is the predicted direction
    logic [1:0] bm_pred;
  } pred_t;

  // request as it enters the cluster
  typedef struct packed {
    logic  valid;
    word_t rs1;
    word_t rs2;
    word_t imm;
    wpc_t  pc;
    logic  auipc;
    logic  call;
    logic  ret;
    logic  jal;
    logic  jalr;
    cond_t cond;
    pred_t pred;
  } branch_req_t;

  // issued op, compare flags already resolved
  typedef struct packed {
    logic  valid;
    word_t operand_1;
    word_t offset;
    wpc_t  pc;
    logic  auipc;
    logic  call;
    logic  ret;
    logic  jal;
    logic  jalr;
    cond_t cond;
    logic  mts;
    logic  mtu;
    logic  eq;
    pred_t pred;
  } branch_op_t;

  // combinational unit result
  typedef struct packed {
    logic   taken;
    btype_t btype;
    word_t  target;
    word_t  result;
  } branch_res_t;

  typedef struct packed {
    logic  valid;
    word_t result;
  } wb_t;

  typedef struct packed {
    logic  valid;
    word_t addr;
    lane_t lane;
  } redirect_t;

  // predictor feedback, one set per lane
  typedef struct packed {
    logic bm_update;
    logic taken;
    logic call_affirm;
    logic ret_affirm;
  } train_t;

endpackage
